// ==== design/axil_config_regs.sv ====
`timescale 1ns/1ps
`include "pixel_readout_params.svh"

module axil_config_regs (
  input  logic                           clk,
  input  logic                           reset_gen,
  input  logic [4:0]                     awaddr,
  input  logic                           awvalid,
  output logic                           awready,
  input  logic [31:0]                    wdata,
  input  logic [3:0]                     wstrb,
  input  logic                           wvalid,
  output logic                           wready,
  output logic [1:0]                     bresp,
  output logic                           bvalid,
  input  logic                           bready,
  input  logic [4:0]                     araddr,
  input  logic                           arvalid,
  output logic                           arready,
  output logic [31:0]                    rdata,
  output logic [1:0]                     rresp,
  output logic                           rvalid,
  input  logic                           rready,
  input  logic                           busy,
  input  logic                           frame_done,
  output logic                           frame_start,
  output pixel_readout_pkg::dac_code_t   vthr,
  output pixel_readout_pkg::dac_code_t   aref,
  output pixel_readout_pkg::dac_code_t   vana,
  output pixel_readout_pkg::dac_code_t   rg,
  output logic [7:0]                     static_levels,
  output pixel_readout_pkg::line_count_t row_count,
  output pixel_readout_pkg::line_count_t col_count
);
  logic        continuous;
  logic        wr_fire;
  logic        rd_fire;
  logic        wr_take;
  logic [31:0] wr_old;
  logic [31:0] wr_new;

  function automatic logic [31:0] reg_value(input logic [4:0] addr);
    case (addr)
      `ADDR_CTRL:   reg_value = {30'd0, continuous, 1'b0};  // Start reads back as 0
      `ADDR_STATIC: reg_value = {24'd0, static_levels};
      `ADDR_DAC0:   reg_value = {aref, vthr};
      `ADDR_DAC1:   reg_value = {rg, vana};
      `ADDR_ROWS:   reg_value = {16'd0, row_count};
      `ADDR_COLS:   reg_value = {16'd0, col_count};
      `ADDR_STATUS: reg_value = {31'd0, busy};
      default:      reg_value = 32'd0;
    endcase
  endfunction

  // Byte-lane merge of the write data into the current register value
  always_comb begin
    wr_old = reg_value(awaddr);
    for (int i = 0; i < 4; i++) begin
      wr_new[8*i +: 8] = wstrb[i] ? wdata[8*i +: 8] : wr_old[8*i +: 8];
    end
  end

  assign wr_take = awvalid & wvalid & ~awready & ~bvalid;
  assign wr_fire = awvalid & awready & wvalid & wready;
  assign rd_fire = arvalid & arready;
  assign bresp   = 2'b00;
  assign rresp   = 2'b00;

  always_ff @(posedge clk) begin
    if (reset_gen) begin
      awready       <= 1'b0;
      wready        <= 1'b0;
      bvalid        <= 1'b0;
      arready       <= 1'b0;
      rvalid        <= 1'b0;
      frame_start   <= 1'b0;
      continuous    <= 1'b0;
      static_levels <= `STATIC_RESET;
      vthr          <= `VTHR_RESET;
      aref          <= `AREF_RESET;
      vana          <= `VANA_RESET;
      rg            <= `RG_RESET;
      row_count     <= `ROWS_RESET;
      col_count     <= `COLS_RESET;
    end else begin
      awready <= wr_take;
      wready  <= wr_take;
      if (wr_fire) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
      arready <= arvalid & ~arready & ~rvalid;
      if (rd_fire) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
      // Start is dropped while a frame runs
      frame_start <= (wr_fire && awaddr == `ADDR_CTRL && wr_new[0] && !busy) ||
                     (continuous && frame_done);
      if (wr_fire) begin
        case (awaddr)
          `ADDR_CTRL:   continuous    <= wr_new[1];
          `ADDR_STATIC: static_levels <= wr_new[7:0];
          `ADDR_DAC0:   {aref, vthr}  <= wr_new;
          `ADDR_DAC1:   {rg, vana}    <= wr_new;
          `ADDR_ROWS:   row_count     <= wr_new[15:0];
          `ADDR_COLS:   col_count     <= wr_new[15:0];
          default:      continuous    <= continuous;  // Status and holes ignore writes
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rdata <= reg_value(araddr);
    end
  end

endmodule

// ==== design/column_scan_sequencer.sv ====
`timescale 1ns/1ps
`include "pixel_readout_params.svh"

module column_scan_sequencer (
  input  logic                           clk,
  input  logic                           reset_gen,
  input  logic                           frame_start,
  input  pixel_readout_pkg::line_count_t col_count,
  output logic                           sbi,
  output logic                           sphi1,
  output logic                           sphi2,
  output logic                           col_done
);
  import pixel_readout_pkg::*;

  localparam cycle_count_t INJECT_LAST = cycle_count_t'(`COL_INJECT_LEN - 1);
  localparam cycle_count_t SHIFT_LAST  = cycle_count_t'(`SHIFT_LEN - 1);

  col_state_t   state;
  col_state_t   cur_state;
  cycle_count_t phase_cnt;
  cycle_count_t cur_cnt;
  line_count_t  step_cnt;

  always_comb begin
    cur_state = frame_start ? COL_INJECT : state;
    cur_cnt   = frame_start ? '0 : phase_cnt;
  end

  assign sbi      = (cur_state == COL_INJECT) && (cur_cnt >= `SBI_ON);
  assign sphi1    = (cur_state == COL_SHIFT) && (cur_cnt == '0);
  assign sphi2    = (cur_state == COL_SHIFT) && (cur_cnt == `SHIFT_PHI2);
  assign col_done = (cur_state == COL_DONE);

  always_ff @(posedge clk) begin
    if (reset_gen) begin
      state     <= COL_IDLE;
      phase_cnt <= '0;
      step_cnt  <= '0;
    end else begin
      state <= cur_state;
      case (cur_state)
        COL_INJECT: begin
          phase_cnt <= (cur_cnt == INJECT_LAST) ? '0 : cur_cnt + 1'b1;
          step_cnt  <= '0;
          if (cur_cnt == INJECT_LAST) begin
            state <= (col_count == '0) ? COL_DONE : COL_SHIFT;  // No columns, token only
          end
        end
        COL_SHIFT: begin
          if (cur_cnt != SHIFT_LAST) begin
            phase_cnt <= cur_cnt + 1'b1;
          end else if (step_cnt + 1'b1 == col_count) begin
            state <= COL_DONE;
          end else begin
            phase_cnt <= '0;
            step_cnt  <= step_cnt + 1'b1;
          end
        end
        default: phase_cnt <= '0;
      endcase
    end
  end

endmodule

// ==== design/pixel_readout_params.svh ====
`ifndef PIXEL_READOUT_PARAMS_SVH
`define PIXEL_READOUT_PARAMS_SVH

// Register map
`define ADDR_CTRL    5'h00
`define ADDR_STATIC  5'h04
`define ADDR_DAC0    5'h08
`define ADDR_DAC1    5'h0C
`define ADDR_ROWS    5'h10
`define ADDR_COLS    5'h14
`define ADDR_STATUS  5'h18

`define VTHR_RESET   16'h0025
`define AREF_RESET   16'h0033
`define VANA_RESET   16'h0066
`define RG_RESET     16'h0033
`define STATIC_RESET 8'h6E     // {CAL,SEB,IS1,IS2,SR,RESET,R12,CS}
`define ROWS_RESET   16'd128
`define COLS_RESET   16'd16

// Row inject phase, cycle numbers from frame start
`define INJECT_LEN   30
`define TOKEN_ON     7
`define TOKEN_OFF    16        // First token window ends before this cycle
`define PHI_LOW      22
`define TOKEN2_ON    24
`define TOKEN2_OFF   27
`define RPHI1_PULSE  25
`define RPHI2_PULSE  28

// Shift step, PHI1 in step cycle 0
`define SHIFT_LEN    4
`define SHIFT_PHI2   2

`define COL_INJECT_LEN 6
`define SBI_ON         2       // SBI high from here to end of column inject

`endif

// ==== design/pixel_readout_pkg.sv ====
package pixel_readout_pkg;

  typedef logic [15:0] dac_code_t;     // One bias DAC code
  typedef logic [15:0] line_count_t;   // Rows or columns to shift
  typedef logic [7:0]  cycle_count_t;  // Cycle inside a sequencer phase

  typedef enum logic [1:0] {
    ROW_IDLE,
    ROW_INJECT,
    ROW_SHIFT,
    ROW_DONE
  } row_state_t;

  typedef enum logic [1:0] {
    COL_IDLE,
    COL_INJECT,
    COL_SHIFT,
    COL_DONE
  } col_state_t;

endpackage

// ==== design/pixel_readout_top.sv ====
`timescale 1ns/1ps

module pixel_readout_top (
  input  logic                         clk,
  input  logic                         reset_gen,
  input  logic [4:0]                   awaddr,
  input  logic                         awvalid,
  output logic                         awready,
  input  logic [31:0]                  wdata,
  input  logic [3:0]                   wstrb,
  input  logic                         wvalid,
  output logic                         wready,
  output logic [1:0]                   bresp,
  output logic                         bvalid,
  input  logic                         bready,
  input  logic [4:0]                   araddr,
  input  logic                         arvalid,
  output logic                         arready,
  output logic [31:0]                  rdata,
  output logic [1:0]                   rresp,
  output logic                         rvalid,
  input  logic                         rready,
  output logic                         RBI,
  output logic                         RPHI1,
  output logic                         RPHI2,
  output logic                         SBI,
  output logic                         SPHI1,
  output logic                         SPHI2,
  output logic                         LE,
  output logic                         CAL,
  output logic                         SEB,
  output logic                         IS1,
  output logic                         IS2,
  output logic                         SR,
  output logic                         RESET,
  output logic                         R12,
  output logic                         CS,
  output pixel_readout_pkg::dac_code_t Vthr,
  output pixel_readout_pkg::dac_code_t Aref,
  output pixel_readout_pkg::dac_code_t Vana,
  output pixel_readout_pkg::dac_code_t RG,
  output logic                         frame_active
);
  import pixel_readout_pkg::*;

  logic        frame_start;
  logic        frame_done;
  logic        busy;
  logic [7:0]  static_levels;
  line_count_t row_count;
  line_count_t col_count;
  logic        rbi, rphi1, rphi2, row_done;
  logic        sbi, sphi1, sphi2, col_done;

  assign {CAL, SEB, IS1, IS2, SR, RESET, R12, CS} = static_levels;

  axil_config_regs u_regs (.*, .vthr(Vthr), .aref(Aref), .vana(Vana), .rg(RG));

  row_scan_sequencer u_row (.*);

  column_scan_sequencer u_col (.*);

  readout_pin_driver u_pins (.*);

endmodule

// ==== design/readout_pin_driver.sv ====
`timescale 1ns/1ps

module readout_pin_driver (
  input  logic clk,
  input  logic reset_gen,
  input  logic frame_start,
  input  logic rbi,
  input  logic rphi1,
  input  logic rphi2,
  input  logic row_done,
  input  logic sbi,
  input  logic sphi1,
  input  logic sphi2,
  input  logic col_done,
  output logic RBI,
  output logic RPHI1,
  output logic RPHI2,
  output logic SBI,
  output logic SPHI1,
  output logic SPHI2,
  output logic LE,
  output logic frame_active,
  output logic busy,
  output logic frame_done
);
  // Covers the start cycle too, so a start write there is refused
  assign busy = frame_start | frame_active;
  assign LE   = frame_done;

  always_ff @(posedge clk) begin
    if (reset_gen) begin
      {RBI, RPHI1, RPHI2, SBI, SPHI1, SPHI2} <= 6'b0;
      frame_active <= 1'b0;
      frame_done   <= 1'b0;
    end else begin
      {RBI, RPHI1, RPHI2} <= {3{busy}} & {rbi, rphi1, rphi2};  // Low while idle
      {SBI, SPHI1, SPHI2} <= {3{busy}} & {sbi, sphi1, sphi2};
      if (frame_start) begin
        frame_active <= 1'b1;
      end else if (frame_done) begin
        frame_active <= 1'b0;
      end
      frame_done <= frame_active & row_done & col_done & ~frame_done;
    end
  end

endmodule

// ==== design/row_scan_sequencer.sv ====
`timescale 1ns/1ps
`include "pixel_readout_params.svh"

module row_scan_sequencer (
  input  logic                           clk,
  input  logic                           reset_gen,
  input  logic                           frame_start,
  input  pixel_readout_pkg::line_count_t row_count,
  output logic                           rbi,
  output logic                           rphi1,
  output logic                           rphi2,
  output logic                           row_done
);
  import pixel_readout_pkg::*;

  localparam cycle_count_t INJECT_LAST = cycle_count_t'(`INJECT_LEN - 1);
  localparam cycle_count_t SHIFT_LAST  = cycle_count_t'(`SHIFT_LEN - 1);

  row_state_t   state;
  row_state_t   cur_state;
  cycle_count_t phase_cnt;
  cycle_count_t cur_cnt;
  line_count_t  step_cnt;

  // frame_start acts as inject cycle 0 before the state register catches up
  always_comb begin
    cur_state = frame_start ? ROW_INJECT : state;
    cur_cnt   = frame_start ? '0 : phase_cnt;
  end

  always_comb begin
    rbi   = 1'b0;
    rphi1 = 1'b0;
    rphi2 = 1'b0;
    if (cur_state == ROW_INJECT) begin
      rbi   = (cur_cnt >= `TOKEN_ON && cur_cnt < `TOKEN_OFF) ||
              (cur_cnt >= `TOKEN2_ON && cur_cnt < `TOKEN2_OFF);
      rphi1 = (cur_cnt < `PHI_LOW) || (cur_cnt == `RPHI1_PULSE);
      rphi2 = (cur_cnt < `PHI_LOW) || (cur_cnt == `RPHI2_PULSE);
    end else if (cur_state == ROW_SHIFT) begin
      rphi1 = (cur_cnt == '0);
      rphi2 = (cur_cnt == `SHIFT_PHI2);
    end
  end

  always_ff @(posedge clk) begin
    if (reset_gen) begin
      state     <= ROW_IDLE;
      phase_cnt <= '0;
      step_cnt  <= '0;
    end else begin
      state <= cur_state;
      case (cur_state)
        ROW_INJECT: begin
          phase_cnt <= (cur_cnt == INJECT_LAST) ? '0 : cur_cnt + 1'b1;
          step_cnt  <= '0;
          if (cur_cnt == INJECT_LAST) begin
            state <= ROW_SHIFT;
          end
        end
        ROW_SHIFT: begin
          if (cur_cnt != SHIFT_LAST) begin
            phase_cnt <= cur_cnt + 1'b1;
          end else if (step_cnt == row_count) begin  // rows+1 steps
            state <= ROW_DONE;
          end else begin
            phase_cnt <= '0;
            step_cnt  <= step_cnt + 1'b1;
          end
        end
        default: phase_cnt <= '0;
      endcase
    end
  end

  assign row_done = (cur_state == ROW_DONE);

endmodule

// ==== pixel_readout.f ====
+incdir+design
design/pixel_readout_pkg.sv
design/axil_config_regs.sv
design/row_scan_sequencer.sv
design/column_scan_sequencer.sv
design/readout_pin_driver.sv
design/pixel_readout_top.sv
sim/tb_pixel_readout.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the pixel_readout testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_pixel_readout -Mdir obj_dir -f pixel_readout.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vtb_pixel_readout
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit 1
fi
exit 0

// ==== sim/tb_pixel_readout.sv ====
`timescale 1ns/1ps
`include "pixel_readout_params.svh"

module tb_pixel_readout;
  import pixel_readout_pkg::*;

  localparam int HALF_PERIOD = 10;
  localparam int AXI_LIMIT   = 32;  // Cycles allowed for any AXI handshake
  localparam int CONT_ROWS   = 4;
  localparam int CONT_COLS   = 3;

  logic        clk;
  logic        reset_gen;
  logic [4:0]  awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [4:0]  araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;
  logic        RBI, RPHI1, RPHI2;
  logic        SBI, SPHI1, SPHI2;
  logic        LE;
  logic        CAL, SEB, IS1, IS2, SR, RESET, R12, CS;
  dac_code_t   Vthr, Aref, Vana, RG;
  logic        frame_active;

  logic [31:0] lfsr_state;
  int          cur_rows;
  int          cur_cols;
  int          frames_seen;
  int          k;
  logic        prev_active;

  pixel_readout_top u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_bit(input string name, input logic got, input logic expected);
    assert (got === expected) else begin
      stop_run($sformatf("mismatch %s: got 0x%0h expected 0x%0h at %0t",
                         name, got, expected, $time));
    end
  endtask

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] expected);
    assert (got === expected) else begin
      stop_run($sformatf("mismatch %s: got 0x%0h expected 0x%0h at %0t",
                         name, got, expected, $time));
    end
  endtask

  // Right-shift Galois form with taps x^32 + x^30 + x^26 + x^25 + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      value = {value[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return value;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_value,
                                              input logic [31:0] new_value,
                                              input logic [3:0] strb);
    logic [31:0] result;
    for (int i = 0; i < 4; i++) begin
      result[8*i +: 8] = strb[i] ? new_value[8*i +: 8] : old_value[8*i +: 8];
    end
    return result;
  endfunction

  function automatic int frame_length(input int rows, input int cols);
    int row_len;
    int col_len;
    row_len = `INJECT_LEN + `SHIFT_LEN * (rows + 1);
    col_len = `COL_INJECT_LEN + `SHIFT_LEN * cols;
    return 1 + ((row_len > col_len) ? row_len : col_len);
  endfunction

  // Bit order {RBI, RPHI1, RPHI2, SBI, SPHI1, SPHI2}
  function automatic logic [5:0] expected_pins(input int k, input int rows, input int cols);
    int         s;
    int         j;
    logic [5:0] pins;
    pins = '0;
    s = k - 1;  // Pins trail the sequencers by one cycle
    if (s < `INJECT_LEN) begin
      pins[5] = (s >= `TOKEN_ON && s < `TOKEN_OFF) || (s >= `TOKEN2_ON && s < `TOKEN2_OFF);
      pins[4] = (s < `PHI_LOW) || (s == `RPHI1_PULSE);
      pins[3] = (s < `PHI_LOW) || (s == `RPHI2_PULSE);
    end else if (s < `INJECT_LEN + `SHIFT_LEN * (rows + 1)) begin
      j = (s - `INJECT_LEN) % `SHIFT_LEN;
      pins[4] = (j == 0);
      pins[3] = (j == `SHIFT_PHI2);
    end
    if (s >= `SBI_ON && s < `COL_INJECT_LEN) begin
      pins[2] = 1'b1;
    end else if (s >= `COL_INJECT_LEN && s < `COL_INJECT_LEN + `SHIFT_LEN * cols) begin
      j = (s - `COL_INJECT_LEN) % `SHIFT_LEN;
      pins[1] = (j == 0);
      pins[0] = (j == `SHIFT_PHI2);
    end
    return pins;
  endfunction

  task automatic axi_write(input logic [4:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input int bstall);
    int waited;
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    waited  = 0;
    while (!(awready && wready)) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > AXI_LIMIT) stop_run("write address and data were never accepted");
    end
    @(posedge clk);  // Transfer at this edge
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    waited  = 0;
    while (!bvalid) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > AXI_LIMIT) stop_run("write response never arrived");
    end
    repeat (bstall) begin
      @(posedge clk);
      #1;
      check_bit("bvalid", bvalid, 1'b1);
      check_word("bresp", {30'd0, bresp}, 32'd0);
    end
    bready = 1'b1;
    @(posedge clk);
    #1;
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [4:0] addr, input int rstall,
                          output logic [31:0] data);
    int waited;
    araddr  = addr;
    arvalid = 1'b1;
    waited  = 0;
    while (!arready) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > AXI_LIMIT) stop_run("read address was never accepted");
    end
    @(posedge clk);
    #1;
    arvalid = 1'b0;
    waited  = 0;
    while (!rvalid) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > AXI_LIMIT) stop_run("read data never arrived");
    end
    data = rdata;
    check_word("rresp", {30'd0, rresp}, 32'd0);
    repeat (rstall) begin
      @(posedge clk);
      #1;
      check_bit("rvalid", rvalid, 1'b1);
      check_word("rdata", rdata, data);  // Held while stalled
    end
    rready = 1'b1;
    @(posedge clk);
    #1;
    rready = 1'b0;
  endtask

  task automatic read_check(input string name, input logic [4:0] addr,
                            input logic [31:0] expected, input int rstall);
    logic [31:0] data;
    axi_read(addr, rstall, data);
    check_word(name, data, expected);
  endtask

  task automatic start_frame(input int rows, input int cols, input logic [31:0] ctrl);
    cur_rows = rows;
    cur_cols = cols;
    axi_write(`ADDR_ROWS, rows, 4'hF, 0);
    axi_write(`ADDR_COLS, cols, 4'hF, 0);
    axi_write(`ADDR_CTRL, ctrl, 4'h1, 0);
  endtask

  task automatic wait_frames(input int count);
    int target;
    int waited;
    target = frames_seen + count;
    waited = 0;
    while (frames_seen < target) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > count * (frame_length(cur_rows, cur_cols) + 2) + AXI_LIMIT) begin
        stop_run("frame did not end in time");
      end
    end
  endtask

  // Frame cycle k is 1 in the first cycle with frame_active high
  always @(negedge clk) begin
    logic [5:0] got_pins;
    logic [5:0] exp_pins;
    got_pins = {RBI, RPHI1, RPHI2, SBI, SPHI1, SPHI2};
    if (reset_gen) begin
      prev_active = 1'b0;
      k = 0;
    end else if (frame_active) begin
      k = prev_active ? k + 1 : 1;
      exp_pins = expected_pins(k, cur_rows, cur_cols);
      check_bit("RBI", got_pins[5], exp_pins[5]);
      check_bit("RPHI1", got_pins[4], exp_pins[4]);
      check_bit("RPHI2", got_pins[3], exp_pins[3]);
      check_bit("SBI", got_pins[2], exp_pins[2]);
      check_bit("SPHI1", got_pins[1], exp_pins[1]);
      check_bit("SPHI2", got_pins[0], exp_pins[0]);
      check_bit("LE", LE, k == frame_length(cur_rows, cur_cols));  // Last frame cycle
      prev_active = 1'b1;
    end else begin
      if (prev_active) begin
        check_word("frame length", k, frame_length(cur_rows, cur_cols));
        frames_seen++;
      end
      check_word("idle pins", {26'd0, got_pins}, 32'd0);
      check_bit("LE", LE, 1'b0);
      prev_active = 1'b0;
    end
  end

  initial begin
    int limit;
    limit = frame_length(int'(`ROWS_RESET), int'(`COLS_RESET)) + frame_length(7, 7) +
            frame_length(3, 18) + 6 * (frame_length(CONT_ROWS, CONT_COLS) + 1) + 2000;
    repeat (limit) @(posedge clk);
    stop_run("watchdog expired before the tests finished");
  end

  initial begin
    logic [31:0] value;
    logic [31:0] dac0_model;
    logic [31:0] dac1_model;
    logic [31:0] static_model;
    int          rows;
    int          cols;
    int          seen;
    reset_gen   = 1'b1;
    awaddr      = '0;
    awvalid     = 1'b0;
    wdata       = '0;
    wstrb       = '0;
    wvalid      = 1'b0;
    bready      = 1'b0;
    araddr      = '0;
    arvalid     = 1'b0;
    rready      = 1'b0;
    lfsr_state  = 32'd99547;
    cur_rows    = int'(`ROWS_RESET);
    cur_cols    = int'(`COLS_RESET);
    frames_seen = 0;
    repeat (8) @(posedge clk);
    #1;
    reset_gen = 1'b0;

    // Reset state
    read_check("ctrl", `ADDR_CTRL, 32'd0, 0);
    read_check("static", `ADDR_STATIC, {24'd0, `STATIC_RESET}, 0);
    read_check("dac0", `ADDR_DAC0, {`AREF_RESET, `VTHR_RESET}, 0);
    read_check("dac1", `ADDR_DAC1, {`RG_RESET, `VANA_RESET}, 0);
    read_check("rows", `ADDR_ROWS, {16'd0, `ROWS_RESET}, 0);
    read_check("cols", `ADDR_COLS, {16'd0, `COLS_RESET}, 0);
    read_check("status", `ADDR_STATUS, 32'd0, 0);
    read_check("unmapped", 5'h1C, 32'd0, 0);
    check_word("Vthr", {16'd0, Vthr}, {16'd0, `VTHR_RESET});
    check_word("Aref", {16'd0, Aref}, {16'd0, `AREF_RESET});
    check_word("Vana", {16'd0, Vana}, {16'd0, `VANA_RESET});
    check_word("RG", {16'd0, RG}, {16'd0, `RG_RESET});
    check_word("pins", {26'd0, RBI, RPHI1, RPHI2, SBI, SPHI1, SPHI2}, 32'd0);
    check_bit("LE", LE, 1'b0);

    // DAC and static writes, full and partial strobes, with stalled responses
    dac0_model = take_bits(32);
    axi_write(`ADDR_DAC0, dac0_model, 4'hF, 5);
    check_word("Vthr", {16'd0, Vthr}, {16'd0, dac0_model[15:0]});
    check_word("Aref", {16'd0, Aref}, {16'd0, dac0_model[31:16]});
    value = take_bits(32);
    dac1_model = merge_bytes({`RG_RESET, `VANA_RESET}, value, 4'b0110);
    axi_write(`ADDR_DAC1, value, 4'b0110, 0);
    check_word("Vana", {16'd0, Vana}, {16'd0, dac1_model[15:0]});
    check_word("RG", {16'd0, RG}, {16'd0, dac1_model[31:16]});
    read_check("dac0", `ADDR_DAC0, dac0_model, 6);
    read_check("dac1", `ADDR_DAC1, dac1_model, 0);
    value = take_bits(32);
    static_model = {24'd0, value[7:0]};
    axi_write(`ADDR_STATIC, value, 4'hF, 0);
    value = take_bits(32);
    static_model = merge_bytes(static_model, value, 4'b1110) & 32'hFF;  // Byte 0 kept
    axi_write(`ADDR_STATIC, value, 4'b1110, 3);
    check_word("static pins", {24'd0, CAL, SEB, IS1, IS2, SR, RESET, R12, CS}, static_model);
    read_check("static", `ADDR_STATIC, static_model, 4);

    // Default frame
    axi_write(`ADDR_CTRL, 32'h1, 4'h1, 0);
    wait_frames(1);

    // Small frames where the second has the longer column sequence
    rows = take_bits(3);
    cols = take_bits(3);
    start_frame(rows, cols, 32'h1);
    wait_frames(1);
    rows = take_bits(2);
    cols = rows + 8 + int'(take_bits(3));
    start_frame(rows, cols, 32'h1);
    wait_frames(1);

    // Continuous mode
    start_frame(CONT_ROWS, CONT_COLS, 32'h3);
    read_check("status", `ADDR_STATUS, 32'd1, 0);
    axi_write(`ADDR_CTRL, 32'h3, 4'h1, 0);  // Start while busy is ignored
    read_check("ctrl", `ADDR_CTRL, 32'h2, 0);
    wait_frames(3);
    axi_write(`ADDR_CTRL, 32'h0, 4'h1, 0);
    wait_frames(1);
    seen = frames_seen;
    repeat (2 * frame_length(CONT_ROWS, CONT_COLS)) @(posedge clk);
    #1;
    check_word("frames seen", frames_seen, seen);
    check_bit("frame_active", frame_active, 1'b0);
    read_check("status", `ADDR_STATUS, 32'd0, 0);

    repeat (4) @(posedge clk);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule
